/* src/spectrum_bus_pkg.sv */
// Spectrum CPU bus definitions
// Z80 address and data widths, border colour width and the
// partial address decode of the paging and ULA I/O ports

package spectrum_bus_pkg;

	// ==============================
	// Bus widths
	// ==============================
	localparam int CPU_ADDR_W = 16;
	localparam int CPU_DATA_W = 8;
	localparam int BORDER_W   = 3;

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [CPU_DATA_W-1:0] cpu_data_t;
	typedef logic [BORDER_W-1:0]   border_t;

	// ==============================
	// I/O port decode
	// ==============================
	// ULA answers on any even port
	localparam int ULA_PORT_BIT = 0;

	// 7FFD needs A15 and A1 low
	localparam cpu_addr_t PAGE_7FFD_MASK = 16'h8002;
	// On the +3, A14 must also be high for 7FFD
	localparam int PAGE_7FFD_SEL_BIT = 14;

	// 1FFD needs A15..A13 and A1 low with A12 high
	localparam cpu_addr_t PAGE_1FFD_MASK  = 16'hF002;
	localparam cpu_addr_t PAGE_1FFD_MATCH = 16'h1000;

	// Port FE data bits
	localparam int FE_MIC_BIT = 3;
	localparam int FE_EAR_BIT = 4;

endpackage

/* src/spectrum_mem_pkg.sv */
// Spectrum memory map definitions
// Physical address layout, page numbers, machine modes and the
// beeper mix weights

package spectrum_mem_pkg;

	// ==============================
	// Physical address
	// ==============================
	// Bit 21 flags ROM and bits 16..14 hold the page above a 14-bit offset
	localparam int PHYS_ADDR_W   = 22;
	localparam int PHYS_ROM_BIT  = 21;
	localparam int PAGE_OFFSET_W = 14;

	typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;

	typedef logic [2:0] ram_page_t;
	typedef logic [1:0] rom_page_t;

	// Pages that sit behind banks 1 and 2 in the normal layout
	localparam ram_page_t PAGE_BANK1 = 3'd5;
	localparam ram_page_t PAGE_BANK2 = 3'd2;

	// ==============================
	// Machine modes
	// ==============================
	typedef logic [1:0] machine_mode_t;

	localparam machine_mode_t MODE_ZX48  = 2'd0;
	localparam machine_mode_t MODE_128   = 2'd1;
	localparam machine_mode_t MODE_PLUS3 = 2'd2;

	// ==============================
	// Beeper mix
	// ==============================
	typedef logic [7:0] audio_level_t;

	localparam audio_level_t EAR_WEIGHT  = 8'd128;
	localparam audio_level_t MIC_WEIGHT  = 8'd64;
	localparam audio_level_t TAPE_WEIGHT = 8'd32;

endpackage

/* src/io_port_decoder.sv */
// I/O port decoder
// Turns a CPU I/O write into write strobes for 7FFD, 1FFD and the
// ULA port FE, using the partial decode of the real machines.
// The paging lock and the +3 mode gate the paging ports here only.

module io_port_decoder (
	input  logic                        io_wr,
	input  spectrum_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                        plus3,
	input  logic                        locked,
	output logic                        wr_7ffd,
	output logic                        wr_1ffd,
	output logic                        wr_fe
);

	logic ula_hit;
	logic page_hit;
	logic page_sel_ok;
	logic plus3_hit;

	// ==============================
	// Address match
	// ==============================
	// Any even port reaches the ULA
	assign ula_hit = ~cpu_addr[spectrum_bus_pkg::ULA_PORT_BIT];

	// 7FFD decodes on A15 and A1 only
	assign page_hit = (cpu_addr & spectrum_bus_pkg::PAGE_7FFD_MASK) == '0;

	// The +3 also looks at A14, so 1FFD does not alias onto 7FFD
	assign page_sel_ok = cpu_addr[spectrum_bus_pkg::PAGE_7FFD_SEL_BIT] | ~plus3;

	assign plus3_hit = (cpu_addr & spectrum_bus_pkg::PAGE_1FFD_MASK)
		== spectrum_bus_pkg::PAGE_1FFD_MATCH;

	// ==============================
	// Write strobes
	// ==============================
	assign wr_fe = io_wr & ula_hit;

	// Paging ports ignore writes once locked
	assign wr_7ffd = io_wr & ~locked & page_hit & page_sel_ok;

	// 1FFD only exists on the +2A/+3
	assign wr_1ffd = io_wr & ~locked & plus3 & plus3_hit;

endmodule

/* src/paging_registers.sv */
// Paging registers
// Latches the machine mode during reset and holds the 7FFD and
// 1FFD registers. Derives the lock, the ROM page, the bank 3 RAM
// page and the special paging controls from them.

module paging_registers (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  spectrum_mem_pkg::machine_mode_t machine_mode,
	input  logic                            wr_7ffd,
	input  logic                            wr_1ffd,
	input  spectrum_bus_pkg::cpu_data_t     cpu_data,
	output logic                            plus3,
	output logic                            locked,
	output spectrum_mem_pkg::ram_page_t     ram_page,
	output spectrum_mem_pkg::rom_page_t     rom_page,
	output logic                            special_mode,
	output logic [1:0]                      special_config,
	output logic                            screen_page
);

	spectrum_mem_pkg::machine_mode_t mode_q;

	// 7FFD bits 5..0 hold lock, ROM, screen and RAM page
	logic [5:0] page_7ffd;
	// 1FFD bit 0 enables special paging and bits 2..1 set config and ROM high bit
	logic [2:0] page_1ffd;

	logic zx48;

	// ==============================
	// Mode latch
	// ==============================
	// Sampled on every reset cycle and unknown codes fall back to 128K
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			case (machine_mode)
				spectrum_mem_pkg::MODE_ZX48,
				spectrum_mem_pkg::MODE_PLUS3: mode_q <= machine_mode;
				default: mode_q <= spectrum_mem_pkg::MODE_128;
			endcase
		end
	end

	// ==============================
	// Port registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else begin
			if (wr_7ffd) begin
				page_7ffd <= cpu_data[5:0];
			end
			if (wr_1ffd) begin
				page_1ffd <= cpu_data[2:0];
			end
		end
	end

	assign zx48  = mode_q == spectrum_mem_pkg::MODE_ZX48;
	assign plus3 = mode_q == spectrum_mem_pkg::MODE_PLUS3;

	// A 48K machine has no paging at all
	assign locked = zx48 | page_7ffd[5];

	// Two ROMs up to the +2 and four on the +3
	always_comb begin
		if (plus3) begin
			rom_page = {page_1ffd[2], page_7ffd[4]};
		end else begin
			rom_page = {1'b0, zx48 | page_7ffd[4]};
		end
	end

	assign ram_page       = page_7ffd[2:0];
	assign screen_page    = page_7ffd[3];
	assign special_mode   = page_1ffd[0];
	assign special_config = page_1ffd[2:1];

endmodule

/* src/address_mapper.sv */
// Address mapper
// Translates each CPU memory access into a physical ROM or RAM
// address, using the normal 128K layout or one of the four +3
// all-RAM layouts. One pipeline stage that drops writes to ROM.

module address_mapper (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         mem_req,
	input  logic                         mem_wr,
	input  spectrum_bus_pkg::cpu_addr_t  cpu_addr,
	input  spectrum_mem_pkg::ram_page_t  ram_page,
	input  spectrum_mem_pkg::rom_page_t  rom_page,
	input  logic                         special_mode,
	input  logic [1:0]                   special_config,
	output logic                         ram_valid,
	output spectrum_mem_pkg::phys_addr_t ram_addr,
	output logic                         ram_we
);

	logic [1:0]                   bank;
	spectrum_mem_pkg::ram_page_t  page_sel;
	logic                         map_rom;
	spectrum_mem_pkg::phys_addr_t phys_next;

	assign bank = cpu_addr[15:14];

	// ==============================
	// Page select
	// ==============================
	always_comb begin
		map_rom  = 1'b0;
		page_sel = ram_page;
		if (special_mode) begin
			// All-RAM layouts of the +3
			case (special_config)
				2'd0: page_sel = {1'b0, bank};
				2'd1: page_sel = {1'b1, bank};
				2'd2: begin
					if (bank == 2'd3) begin
						page_sel = 3'd3;
					end else begin
						page_sel = {1'b1, bank};
					end
				end
				default: begin
					case (bank)
						2'd0: page_sel = 3'd4;
						2'd1: page_sel = 3'd7;
						2'd2: page_sel = 3'd6;
						default: page_sel = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (bank)
				2'd0: begin
					map_rom  = 1'b1;
					page_sel = {1'b0, rom_page};
				end
				2'd1: page_sel = spectrum_mem_pkg::PAGE_BANK1;
				2'd2: page_sel = spectrum_mem_pkg::PAGE_BANK2;
				default: page_sel = ram_page;
			endcase
		end
	end

	// Flag, page and offset packed into the physical address
	always_comb begin
		phys_next = '0;
		phys_next[spectrum_mem_pkg::PHYS_ROM_BIT] = map_rom;
		phys_next[spectrum_mem_pkg::PAGE_OFFSET_W +: 3] = page_sel;
		phys_next[spectrum_mem_pkg::PAGE_OFFSET_W-1:0] =
			cpu_addr[spectrum_mem_pkg::PAGE_OFFSET_W-1:0];
	end

	// ==============================
	// Output stage
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_valid <= 1'b0;
			ram_we    <= 1'b0;
		end else begin
			ram_valid <= mem_req;
			// ROM is read only
			ram_we    <= mem_req & mem_wr & ~map_rom;
		end
	end

	// Address holds between accesses
	always_ff @(posedge clk_sys) begin
		if (mem_req) begin
			ram_addr <= phys_next;
		end
	end

endmodule

/* src/ula_port.sv */
// ULA port FE
// Holds the border colour and the EAR and MIC outputs written
// through port FE, and mixes EAR, MIC and tape input into the
// beeper level

module ula_port (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           wr_fe,
	input  spectrum_bus_pkg::cpu_data_t    cpu_data,
	input  logic                           tape_in,
	output spectrum_bus_pkg::border_t      border,
	output logic                           ear_out,
	output logic                           mic_out,
	output spectrum_mem_pkg::audio_level_t beeper_level
);

	spectrum_mem_pkg::audio_level_t ear_level;
	spectrum_mem_pkg::audio_level_t mic_level;
	spectrum_mem_pkg::audio_level_t tape_level;

	// ==============================
	// Port register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (wr_fe) begin
			border  <= cpu_data[spectrum_bus_pkg::BORDER_W-1:0];
			ear_out <= cpu_data[spectrum_bus_pkg::FE_EAR_BIT];
			mic_out <= cpu_data[spectrum_bus_pkg::FE_MIC_BIT];
		end
	end

	// ==============================
	// Beeper mix
	// ==============================
	// Weights sum to at most 224 and stay within the level range
	assign ear_level  = ear_out ? spectrum_mem_pkg::EAR_WEIGHT : '0;
	assign mic_level  = mic_out ? spectrum_mem_pkg::MIC_WEIGHT : '0;
	assign tape_level = tape_in ? spectrum_mem_pkg::TAPE_WEIGHT : '0;

	assign beeper_level = ear_level + mic_level + tape_level;

endmodule

/* src/spectrum_paging.sv */
// Spectrum paging and ULA port unit
// Decodes CPU port writes, keeps the paging registers, maps CPU
// memory accesses onto physical ROM and RAM, and holds the ULA
// border, EAR and MIC state

module spectrum_paging (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  spectrum_mem_pkg::machine_mode_t machine_mode,
	input  spectrum_bus_pkg::cpu_addr_t     cpu_addr,
	input  spectrum_bus_pkg::cpu_data_t     cpu_data,
	input  logic                            io_wr,
	input  logic                            mem_req,
	input  logic                            mem_wr,
	input  logic                            tape_in,
	output logic                            ram_valid,
	output spectrum_mem_pkg::phys_addr_t    ram_addr,
	output logic                            ram_we,
	output logic                            screen_page,
	output spectrum_bus_pkg::border_t       border,
	output logic                            ear_out,
	output logic                            mic_out,
	output spectrum_mem_pkg::audio_level_t  beeper_level
);

	logic                        wr_7ffd;
	logic                        wr_1ffd;
	logic                        wr_fe;
	logic                        plus3;
	logic                        locked;
	spectrum_mem_pkg::ram_page_t ram_page;
	spectrum_mem_pkg::rom_page_t rom_page;
	logic                        special_mode;
	logic [1:0]                  special_config;

	io_port_decoder io_port_decoder_i (
		.io_wr    (io_wr),
		.cpu_addr (cpu_addr),
		.plus3    (plus3),
		.locked   (locked),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_fe    (wr_fe)
	);

	paging_registers paging_registers_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.machine_mode   (machine_mode),
		.wr_7ffd        (wr_7ffd),
		.wr_1ffd        (wr_1ffd),
		.cpu_data       (cpu_data),
		.plus3          (plus3),
		.locked         (locked),
		.ram_page       (ram_page),
		.rom_page       (rom_page),
		.special_mode   (special_mode),
		.special_config (special_config),
		.screen_page    (screen_page)
	);

	address_mapper address_mapper_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mem_req        (mem_req),
		.mem_wr         (mem_wr),
		.cpu_addr       (cpu_addr),
		.ram_page       (ram_page),
		.rom_page       (rom_page),
		.special_mode   (special_mode),
		.special_config (special_config),
		.ram_valid      (ram_valid),
		.ram_addr       (ram_addr),
		.ram_we         (ram_we)
	);

	ula_port ula_port_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_fe        (wr_fe),
		.cpu_data     (cpu_data),
		.tape_in      (tape_in),
		.border       (border),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.beeper_level (beeper_level)
	);

endmodule

/* verification/spectrum_paging_asserts.sv */
// Spectrum paging assertions
// Concurrent checks on the memory pipeline and the port FE
// outputs, bound onto the top level

module spectrum_paging_asserts (
	input logic                         clk_sys,
	input logic                         reset,
	input logic                         mem_req,
	input logic                         ram_valid,
	input spectrum_mem_pkg::phys_addr_t ram_addr,
	input logic                         ram_we,
	input logic                         ear_out,
	input logic                         mic_out
);

	// ==============================
	// Memory pipeline
	// ==============================
	// One cycle from request to valid
	valid_follows_req: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> ram_valid == $past(mem_req)
	) else $error("ram_valid does not follow mem_req by one cycle");

	// ROM is never written
	no_rom_write: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> !ram_addr[spectrum_mem_pkg::PHYS_ROM_BIT]
	) else $error("ram_we set for a ROM address");

	// ==============================
	// Port FE
	// ==============================
	fe_cleared: assert property (
		@(posedge clk_sys)
		$past(reset) && !reset |-> !ear_out && !mic_out
	) else $error("ear_out or mic_out set after reset");

endmodule

bind spectrum_paging spectrum_paging_asserts spectrum_paging_asserts_i (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.mem_req   (mem_req),
	.ram_valid (ram_valid),
	.ram_addr  (ram_addr),
	.ram_we    (ram_we),
	.ear_out   (ear_out),
	.mic_out   (mic_out)
);

/* verification/spectrum_paging_tb.sv */
// Spectrum paging testbench
// Drives port writes and memory accesses in the ZX-48, 128K and +3
// modes and checks every output against a cycle model of the unit

module spectrum_paging_tb;

	localparam int CLK_HALF       = 4;
	localparam int DRIVE_DELAY    = 1;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 8;

	logic                            clk_sys;
	logic                            reset;
	spectrum_mem_pkg::machine_mode_t machine_mode;
	spectrum_bus_pkg::cpu_addr_t     cpu_addr;
	spectrum_bus_pkg::cpu_data_t     cpu_data;
	logic                            io_wr;
	logic                            mem_req;
	logic                            mem_wr;
	logic                            tape_in;
	logic                            ram_valid;
	spectrum_mem_pkg::phys_addr_t    ram_addr;
	logic                            ram_we;
	logic                            screen_page;
	spectrum_bus_pkg::border_t       border;
	logic                            ear_out;
	logic                            mic_out;
	spectrum_mem_pkg::audio_level_t  beeper_level;

	// Shadow of the unit state that follows each rising edge
	spectrum_mem_pkg::machine_mode_t mode_m;
	logic [5:0]                      reg_7ffd;
	logic [2:0]                      reg_1ffd;
	spectrum_bus_pkg::border_t       border_m;
	logic                            ear_m;
	logic                            mic_m;
	logic                            locked_m;
	logic                            exp_valid;
	logic                            exp_we;
	spectrum_mem_pkg::phys_addr_t    exp_addr;
	logic [31:0]                     rnd;

	spectrum_paging spectrum_paging_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine_mode (machine_mode),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.io_wr        (io_wr),
		.mem_req      (mem_req),
		.mem_wr       (mem_wr),
		.tape_in      (tape_in),
		.ram_valid    (ram_valid),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.screen_page  (screen_page),
		.border       (border),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.beeper_level (beeper_level)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	// ==============================
	// Reporting
	// ==============================
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected));
		end
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic spectrum_mem_pkg::phys_addr_t expected_phys(
		input spectrum_mem_pkg::machine_mode_t mode,
		input logic [5:0]                      p7,
		input logic [2:0]                      p1,
		input spectrum_bus_pkg::cpu_addr_t     addr
	);
		logic [1:0]  bank;
		logic [11:0] layout;
		logic [2:0]  page;
		logic        rom;
		bank = addr[15:14];
		rom  = 1'b0;
		if (p1[0]) begin
			// Pages of banks 3 down to 0
			case (p1[2:1])
				2'd0: layout = {3'd3, 3'd2, 3'd1, 3'd0};
				2'd1: layout = {3'd7, 3'd6, 3'd5, 3'd4};
				2'd2: layout = {3'd3, 3'd6, 3'd5, 3'd4};
				default: layout = {3'd3, 3'd6, 3'd7, 3'd4};
			endcase
			page = layout[3*bank +: 3];
		end else if (bank == 2'd0) begin
			rom = 1'b1;
			if (mode == spectrum_mem_pkg::MODE_PLUS3) begin
				page = {1'b0, p1[2], p7[4]};
			end else if (mode == spectrum_mem_pkg::MODE_ZX48) begin
				page = 3'd1;
			end else begin
				page = {2'b00, p7[4]};
			end
		end else if (bank == 2'd1) begin
			page = 3'd5;
		end else if (bank == 2'd2) begin
			page = 3'd2;
		end else begin
			page = p7[2:0];
		end
		return {rom, 4'b0000, page, addr[13:0]};
	endfunction

	function automatic spectrum_mem_pkg::audio_level_t beeper_sum(input logic ear,
		input logic mic, input logic tape);
		spectrum_mem_pkg::audio_level_t sum;
		sum = 8'd0;
		if (ear) begin
			sum = sum + spectrum_mem_pkg::EAR_WEIGHT;
		end
		if (mic) begin
			sum = sum + spectrum_mem_pkg::MIC_WEIGHT;
		end
		if (tape) begin
			sum = sum + spectrum_mem_pkg::TAPE_WEIGHT;
		end
		return sum;
	endfunction

	// Mapping uses the state from before this edge's port writes
	always @(posedge clk_sys) begin
		if (reset) begin
			mode_m    = machine_mode;
			reg_7ffd  = '0;
			reg_1ffd  = '0;
			border_m  = '0;
			ear_m     = 1'b0;
			mic_m     = 1'b0;
			exp_valid = 1'b0;
			exp_we    = 1'b0;
		end else begin
			exp_valid = mem_req;
			exp_we    = 1'b0;
			if (mem_req) begin
				exp_addr = expected_phys(mode_m, reg_7ffd, reg_1ffd, cpu_addr);
				exp_we   = mem_wr & ~exp_addr[21];
			end
			if (io_wr) begin
				locked_m = (mode_m == spectrum_mem_pkg::MODE_ZX48) || reg_7ffd[5];
				if (!cpu_addr[0]) begin
					border_m = cpu_data[2:0];
					mic_m    = cpu_data[3];
					ear_m    = cpu_data[4];
				end
				if (!locked_m && !cpu_addr[15] && !cpu_addr[1] &&
					(cpu_addr[14] || mode_m != spectrum_mem_pkg::MODE_PLUS3)) begin
					reg_7ffd = cpu_data[5:0];
				end
				if (!locked_m && mode_m == spectrum_mem_pkg::MODE_PLUS3 &&
					cpu_addr[15:12] == 4'b0001 && !cpu_addr[1]) begin
					reg_1ffd = cpu_data[2:0];
				end
			end
		end
	end

	// Check all outputs against the shadow once per cycle
	always @(negedge clk_sys) begin
		if (!reset) begin
			check_value("ram_valid", 32'(ram_valid), 32'(exp_valid));
			check_value("ram_we", 32'(ram_we), 32'(exp_we));
			if (exp_valid) begin
				check_value("ram_addr", 32'(ram_addr), 32'(exp_addr));
			end
			check_value("screen_page", 32'(screen_page), 32'(reg_7ffd[3]));
			check_value("border", 32'(border), 32'(border_m));
			check_value("ear_out", 32'(ear_out), 32'(ear_m));
			check_value("mic_out", 32'(mic_out), 32'(mic_m));
			check_value("beeper_level", 32'(beeper_level),
				32'(beeper_sum(ear_m, mic_m, tape_in)));
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic apply_reset(input spectrum_mem_pkg::machine_mode_t mode);
		machine_mode = mode;
		reset        = 1'b1;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	task automatic io_write(input spectrum_bus_pkg::cpu_addr_t addr,
		input spectrum_bus_pkg::cpu_data_t data);
		cpu_addr = addr;
		cpu_data = data;
		io_wr    = 1'b1;
		next_cycle();
		io_wr = 1'b0;
	endtask

	task automatic wait_ram_valid(input logic level);
		int cycles;
		cycles = 0;
		while (ram_valid !== level) begin
			if (cycles == TIMEOUT_CYCLES) begin
				fail_run("Timeout while waiting for ram_valid to change");
			end else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	task automatic mem_access(input logic [1:0] bank, input logic wr);
		rnd      = $urandom();
		cpu_addr = {bank, rnd[13:0]};
		mem_wr   = wr;
		mem_req  = 1'b1;
		next_cycle();
		mem_req = 1'b0;
		mem_wr  = 1'b0;
		wait_ram_valid(1'b1);
	endtask

	task automatic sweep_banks();
		for (int b = 0; b < 4; b++) begin
			rnd = $urandom();
			mem_access(2'(b), rnd[0]);
		end
	endtask

	// Strobes on consecutive cycles without gaps
	task automatic mem_burst(input int count);
		for (int i = 0; i < count; i++) begin
			rnd      = $urandom();
			cpu_addr = rnd[15:0];
			mem_wr   = rnd[16];
			mem_req  = 1'b1;
			next_cycle();
		end
		mem_req = 1'b0;
		mem_wr  = 1'b0;
		wait_ram_valid(1'b0);
	endtask

	initial begin
		void'($urandom(10));
		reset        = 1'b1;
		machine_mode = spectrum_mem_pkg::MODE_128;
		cpu_addr     = '0;
		cpu_data     = '0;
		io_wr        = 1'b0;
		mem_req      = 1'b0;
		mem_wr       = 1'b0;
		tape_in      = 1'b0;
		apply_reset(spectrum_mem_pkg::MODE_128);

		// 128K layout with the lock bit kept clear
		for (int i = 0; i < 12; i++) begin
			rnd = $urandom();
			io_write(16'h7FFD, rnd[7:0] & 8'hDF);
			sweep_banks();
		end
		mem_access(2'd0, 1'b1);
		mem_access(2'd3, 1'b1);

		// Locking makes later writes to both paging ports ineffective
		io_write(16'h7FFD, 8'h23);
		io_write(16'h7FFD, 8'h1C);
		io_write(16'h1FFD, 8'h1E);
		sweep_banks();
		apply_reset(spectrum_mem_pkg::MODE_ZX48);
		io_write(16'h7FFD, 8'h1F);
		sweep_banks();

		// +3 special configs
		apply_reset(spectrum_mem_pkg::MODE_PLUS3);
		io_write(16'h7FFD, 8'h06);
		for (int c = 0; c < 4; c++) begin
			io_write(16'h1FFD, 8'(2 * c + 1));
			sweep_banks();
		end
		// ROM page high bit from 1FFD
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		sweep_banks();
		io_write(16'h1FFD, 8'h00);
		sweep_banks();
		io_write(16'h7FFD, 8'h20);
		io_write(16'h1FFD, 8'h01);
		sweep_banks();

		// Port FE with every EAR, MIC and tape combination
		for (int v = 0; v < 8; v++) begin
			rnd     = $urandom();
			tape_in = v[2];
			io_write({rnd[15:1], 1'b0}, {3'b000, v[1], v[0], rnd[18:16]});
			next_cycle();
		end
		tape_in = 1'b0;

		// Back-to-back accesses
		apply_reset(spectrum_mem_pkg::MODE_128);
		io_write(16'h7FFD, 8'h17);
		mem_burst(24);
		apply_reset(spectrum_mem_pkg::MODE_PLUS3);
		io_write(16'h1FFD, 8'h05);
		mem_burst(24);

		next_cycle();
		$display("Regression passed");
		$finish;
	end

endmodule

/* spectrum_paging.f */
src/spectrum_bus_pkg.sv
src/spectrum_mem_pkg.sv
src/io_port_decoder.sv
src/paging_registers.sv
src/address_mapper.sv
src/ula_port.sv
src/spectrum_paging.sv
verification/spectrum_paging_asserts.sv
verification/spectrum_paging_tb.sv

/* Makefile */
# Verilator build and run of the Spectrum paging unit testbench

VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := spectrum_paging_tb
FILELIST   := spectrum_paging.f
BUILD_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
